// ==== source/manycore_pkg.sv ====
package manycore_pkg;

   // store request field widths
   localparam int addr_width = 16;
   localparam int data_width = 32;
   localparam int mask_width = 4;

   // tile coordinates in the mesh
   localparam int x_cord_width = 4;
   localparam int y_cord_width = 4;

   // input FIFO sizing
   localparam int fifo_els = 4;
   localparam int fifo_ptr_width = $clog2(fifo_els);
   localparam int fifo_count_width = $clog2(fifo_els + 1);

   // outgoing credits, counter holds 0 .. max_out_credits
   localparam int max_out_credits = 8;
   localparam int credit_width = $clog2(max_out_credits + 1);

   // tile starts out frozen
   localparam logic freeze_init = 1'b1;

   // code 3 is not decoded and counts as unknown
   typedef enum logic [1:0]
   {
      op_store    = 2'd0,
      op_freeze   = 2'd1,
      op_unfreeze = 2'd2
   } packet_op_e;

   // request packet on the forward network, 70 bits
   typedef struct packed
   {
      packet_op_e              op;
      logic [addr_width-1:0]   addr;
      logic [data_width-1:0]   data;
      logic [mask_width-1:0]   mask;
      logic [x_cord_width-1:0] src_x;
      logic [y_cord_width-1:0] src_y;
      logic [x_cord_width-1:0] dst_x;
      logic [y_cord_width-1:0] dst_y;
   } packet_s;

   // credit going back to the sender, x in the low bits
   typedef struct packed
   {
      logic [y_cord_width-1:0] y_cord;
      logic [x_cord_width-1:0] x_cord;
   } return_packet_s;

   typedef struct packed
   {
      logic    v;
      packet_s data;
   } fwd_link_s;

   // reverse network always accepts, so no ready
   typedef struct packed
   {
      logic           v;
      return_packet_s data;
   } rev_link_s;

   // one direction of a mesh link
   typedef struct packed
   {
      fwd_link_s fwd;
      logic      fwd_ready;
      rev_link_s rev;
   } link_sif_s;

   typedef logic [credit_width-1:0] credit_t;

   // remote store handed to the tile
   typedef struct packed
   {
      logic [addr_width-1:0] addr;
      logic [data_width-1:0] data;
      logic [mask_width-1:0] mask;
   } store_req_s;

endpackage

// ==== source/packet_fifo.sv ====
`timescale 1ns/1ps

module packet_fifo
(
   input  logic                  clk_i,
   input  logic                  reset_i,

   // write side, valid/ready
   input  logic                  in_v_i,
   input  manycore_pkg::packet_s in_packet_i,
   output logic                  in_ready_o,

   // read side, valid/yumi
   output logic                  out_v_o,
   output manycore_pkg::packet_s out_packet_o,
   input  logic                  out_yumi_i
);

   manycore_pkg::packet_s mem [manycore_pkg::fifo_els];

   logic [manycore_pkg::fifo_ptr_width-1:0]   wr_ptr_r;
   logic [manycore_pkg::fifo_ptr_width-1:0]   rd_ptr_r;
   logic [manycore_pkg::fifo_count_width-1:0] count_r;

   logic full;
   logic empty;
   logic push;
   logic pop;

   assign full  = (count_r == manycore_pkg::fifo_count_width'(manycore_pkg::fifo_els));
   assign empty = (count_r == '0);

   assign in_ready_o   = ~full;
   assign out_v_o      = ~empty;
   assign out_packet_o = mem[rd_ptr_r];

   assign push = in_v_i & ~full;
   assign pop  = out_yumi_i & ~empty;

   // payload storage
   always_ff @(posedge clk_i)
   begin
      if (push)
         mem[wr_ptr_r] <= in_packet_i;
   end

   // pointers wrap at the last entry
   always_ff @(posedge clk_i)
   begin
      if (reset_i)
      begin
         wr_ptr_r <= '0;
         rd_ptr_r <= '0;
         count_r  <= '0;
      end
      else
      begin
         if (push)
            wr_ptr_r <= (wr_ptr_r == manycore_pkg::fifo_ptr_width'(manycore_pkg::fifo_els - 1))
                        ? '0 : wr_ptr_r + 1'b1;
         if (pop)
            rd_ptr_r <= (rd_ptr_r == manycore_pkg::fifo_ptr_width'(manycore_pkg::fifo_els - 1))
                        ? '0 : rd_ptr_r + 1'b1;
         // push and pop together leave the count alone
         if (push & ~pop)
            count_r <= count_r + 1'b1;
         else if (pop & ~push)
            count_r <= count_r - 1'b1;
      end
   end

   // consumer must only dequeue a valid head
   a_no_yumi_when_empty: assert property (@(posedge clk_i) disable iff (reset_i)
      out_yumi_i |-> out_v_o);

endmodule

// ==== source/network_endpoint.sv ====
`timescale 1ns/1ps

module network_endpoint
(
   input  logic                    clk_i,
   input  logic                    reset_i,

   // mesh link, both directions
   input  manycore_pkg::link_sif_s link_sif_i,
   output manycore_pkg::link_sif_s link_sif_o,

   // head of the input FIFO
   output logic                    fifo_v_o,
   output manycore_pkg::packet_s   fifo_packet_o,
   input  logic                    fifo_yumi_i,

   // local packet, already qualified as a launch
   input  logic                    out_v_i,
   input  manycore_pkg::packet_s   out_packet_i,

   // one pulse per credit coming back
   output logic                    credit_v_o
);

   logic                         fifo_ready;
   logic                         rev_v_r;
   manycore_pkg::return_packet_s rev_data_r;

   // incoming forward traffic lands in the FIFO
   packet_fifo i_packet_fifo
   (
      .clk_i        (clk_i),
      .reset_i      (reset_i),
      .in_v_i       (link_sif_i.fwd.v),
      .in_packet_i  (link_sif_i.fwd.data),
      .in_ready_o   (fifo_ready),
      .out_v_o      (fifo_v_o),
      .out_packet_o (fifo_packet_o),
      .out_yumi_i   (fifo_yumi_i)
   );

   // return packet valid, one per dequeue
   always_ff @(posedge clk_i)
   begin
      if (reset_i)
         rev_v_r <= 1'b0;
      else
         rev_v_r <= fifo_yumi_i;
   end

   // address the credit to whoever sent the head packet
   always_ff @(posedge clk_i)
   begin
      if (fifo_yumi_i)
      begin
         rev_data_r.x_cord <= fifo_packet_o.src_x;
         rev_data_r.y_cord <= fifo_packet_o.src_y;
      end
   end

   // assemble the outgoing link
   always_comb
   begin
      link_sif_o.fwd.v     = out_v_i;
      link_sif_o.fwd.data  = out_packet_i;
      link_sif_o.fwd_ready = fifo_ready;
      link_sif_o.rev.v     = rev_v_r;
      link_sif_o.rev.data  = rev_data_r;
   end

   // credits for our own earlier launches
   assign credit_v_o = link_sif_i.rev.v;

endmodule

// ==== source/packet_decode.sv ====
`timescale 1ns/1ps

module packet_decode
(
   input  logic                     v_i,
   input  manycore_pkg::packet_s    packet_i,

   output logic                     pkt_freeze_o,
   output logic                     pkt_unfreeze_o,
   output logic                     pkt_unknown_o,

   output logic                     store_v_o,
   output manycore_pkg::store_req_s store_req_o
);

   logic is_store;
   logic is_freeze;
   logic is_unfreeze;
   logic is_unknown;

   // opcode sort
   always_comb
   begin
      is_store    = 1'b0;
      is_freeze   = 1'b0;
      is_unfreeze = 1'b0;
      is_unknown  = 1'b0;
      case (packet_i.op)
         manycore_pkg::op_store:    is_store    = 1'b1;
         manycore_pkg::op_freeze:   is_freeze   = 1'b1;
         manycore_pkg::op_unfreeze: is_unfreeze = 1'b1;
         default:                   is_unknown  = 1'b1;
      endcase
   end

   // nothing fires without a valid head
   assign store_v_o      = v_i & is_store;
   assign pkt_freeze_o   = v_i & is_freeze;
   assign pkt_unfreeze_o = v_i & is_unfreeze;
   assign pkt_unknown_o  = v_i & is_unknown;

   // remote store fields
   always_comb
   begin
      store_req_o.addr = packet_i.addr;
      store_req_o.data = packet_i.data;
      store_req_o.mask = packet_i.mask;
   end

endmodule

// ==== source/credit_counter.sv ====
`timescale 1ns/1ps

module credit_counter
(
   input  logic                  clk_i,
   input  logic                  reset_i,

   // down on launch, up on returned credit
   input  logic                  down_i,
   input  logic                  up_i,

   output manycore_pkg::credit_t count_o
);

   localparam manycore_pkg::credit_t count_max =
      manycore_pkg::credit_t'(manycore_pkg::max_out_credits);

   manycore_pkg::credit_t count_r;

   assign count_o = count_r;

   // all credits available out of reset
   always_ff @(posedge clk_i)
   begin
      if (reset_i)
         count_r <= count_max;
      else if (up_i & ~down_i)
      begin
         if (count_r != count_max)
            count_r <= count_r + 1'b1;
      end
      else if (down_i & ~up_i)
      begin
         if (count_r != '0)
            count_r <= count_r - 1'b1;
      end
   end

   // launching with no credit left would underflow
   a_no_underflow: assert property (@(posedge clk_i) disable iff (reset_i)
      (down_i & ~up_i) |-> (count_r != '0));

   // more credits back than were sent out
   a_no_overflow: assert property (@(posedge clk_i) disable iff (reset_i)
      (up_i & ~down_i) |-> (count_r != count_max));

endmodule

// ==== source/endpoint_standard.sv ====
`timescale 1ns/1ps

module endpoint_standard
(
   input  logic                                    clk_i,
   input  logic                                    reset_i,

   // mesh network
   input  manycore_pkg::link_sif_s                 link_sif_i,
   output manycore_pkg::link_sif_s                 link_sif_o,

   // local incoming remote stores, valid/yumi
   output logic                                    in_v_o,
   output manycore_pkg::store_req_s                in_store_o,
   input  logic                                    in_yumi_i,

   // local outgoing packets, valid/ready
   input  logic                                    out_v_i,
   input  manycore_pkg::packet_s                   out_packet_i,
   output logic                                    out_ready_o,

   output manycore_pkg::credit_t                   out_credits_o,

   // tile coordinates
   input  logic [manycore_pkg::x_cord_width-1:0]   my_x_i,
   input  logic [manycore_pkg::y_cord_width-1:0]   my_y_i,

   output logic                                    freeze_r_o
);

   logic                  fifo_v;
   manycore_pkg::packet_s fifo_packet;
   logic                  fifo_yumi;

   logic pkt_freeze;
   logic pkt_unfreeze;
   logic pkt_unknown;
   logic credit_v;
   logic launch;
   logic freeze_r;

   // network ready and at least one credit left
   assign out_ready_o = link_sif_i.fwd_ready & (out_credits_o != '0);
   assign launch      = out_v_i & out_ready_o;

   // dequeue on a taken store or on either freeze command
   assign fifo_yumi = in_yumi_i | pkt_freeze | pkt_unfreeze;

   network_endpoint i_network_endpoint
   (
      .clk_i         (clk_i),
      .reset_i       (reset_i),
      .link_sif_i    (link_sif_i),
      .link_sif_o    (link_sif_o),
      .fifo_v_o      (fifo_v),
      .fifo_packet_o (fifo_packet),
      .fifo_yumi_i   (fifo_yumi),
      .out_v_i       (launch),
      .out_packet_i  (out_packet_i),
      .credit_v_o    (credit_v)
   );

   packet_decode i_packet_decode
   (
      .v_i            (fifo_v),
      .packet_i       (fifo_packet),
      .pkt_freeze_o   (pkt_freeze),
      .pkt_unfreeze_o (pkt_unfreeze),
      .pkt_unknown_o  (pkt_unknown),
      .store_v_o      (in_v_o),
      .store_req_o    (in_store_o)
   );

   credit_counter i_credit_counter
   (
      .clk_i   (clk_i),
      .reset_i (reset_i),
      .down_i  (launch),
      .up_i    (credit_v),
      .count_o (out_credits_o)
   );

   // freeze register, set by freeze and cleared by unfreeze
   always_ff @(posedge clk_i)
   begin
      if (reset_i)
         freeze_r <= manycore_pkg::freeze_init;
      else if (pkt_freeze | pkt_unfreeze)
         freeze_r <= pkt_freeze;
   end

   assign freeze_r_o = freeze_r;

   // an unknown opcode would sit at the head forever
   a_no_unknown_packet: assert property (@(posedge clk_i) disable iff (reset_i)
      !pkt_unknown);

   // credits must come back to this tile
   a_credit_for_this_tile: assert property (@(posedge clk_i) disable iff (reset_i)
      link_sif_i.rev.v |-> ((link_sif_i.rev.data.x_cord == my_x_i)
                            && (link_sif_i.rev.data.y_cord == my_y_i)));

endmodule

// ==== tests/tb_endpoint_standard.sv ====
`timescale 1ns/1ps

module tb_endpoint_standard;

   typedef enum logic [2:0]
   {
      act_idle,
      act_inject,
      act_yumi,
      act_launch,
      act_credit
   } action_e;

   // one table row holds stimulus and the results expected after it
   typedef struct packed
   {
      action_e                      action;
      manycore_pkg::packet_s        pkt;
      int unsigned                  settle;
      logic                         exp_fwd_v;
      logic                         exp_in_v;
      manycore_pkg::store_req_s     exp_store;
      logic                         exp_rev_v;
      manycore_pkg::return_packet_s exp_ret;
      manycore_pkg::credit_t        exp_credits;
      logic                         exp_freeze;
      logic                         exp_out_ready;
      logic                         exp_fwd_ready;
   } row_s;

   logic                                  clk_i;
   logic                                  reset_i;
   manycore_pkg::link_sif_s               link_sif_i;
   manycore_pkg::link_sif_s               link_sif_o;
   logic                                  in_v_o;
   manycore_pkg::store_req_s              in_store_o;
   logic                                  in_yumi_i;
   logic                                  out_v_i;
   manycore_pkg::packet_s                 out_packet_i;
   logic                                  out_ready_o;
   manycore_pkg::credit_t                 out_credits_o;
   logic [manycore_pkg::x_cord_width-1:0] my_x_i;
   logic [manycore_pkg::y_cord_width-1:0] my_y_i;
   logic                                  freeze_r_o;

   row_s                  table_q [$];
   manycore_pkg::packet_s model_q [$];
   int                    model_credits;
   logic                  model_freeze;
   integer                seed = 84;
   int                    row_errors;
   int                    pass_count;
   int                    fail_count;
   int                    cycle_count;
   int                    timeout_limit;
   logic                  table_ready = 1'b0;

   endpoint_standard i_endpoint_standard
   (
      .clk_i         (clk_i),
      .reset_i       (reset_i),
      .link_sif_i    (link_sif_i),
      .link_sif_o    (link_sif_o),
      .in_v_o        (in_v_o),
      .in_store_o    (in_store_o),
      .in_yumi_i     (in_yumi_i),
      .out_v_i       (out_v_i),
      .out_packet_i  (out_packet_i),
      .out_ready_o   (out_ready_o),
      .out_credits_o (out_credits_o),
      .my_x_i        (my_x_i),
      .my_y_i        (my_y_i),
      .freeze_r_o    (freeze_r_o)
   );

   initial
   begin
      clk_i = 1'b0;
      forever #50 clk_i = ~clk_i;
   end

   function automatic manycore_pkg::packet_s make_packet(input manycore_pkg::packet_op_e op,
                                                         input logic [3:0] src_x,
                                                         input logic [3:0] src_y);
      manycore_pkg::packet_s pkt;
      pkt.op    = op;
      pkt.addr  = manycore_pkg::addr_width'($random(seed));
      pkt.data  = manycore_pkg::data_width'($random(seed));
      pkt.mask  = manycore_pkg::mask_width'($random(seed));
      pkt.src_x = src_x;
      pkt.src_y = src_y;
      pkt.dst_x = my_x_i;
      pkt.dst_y = my_y_i;
      return pkt;
   endfunction

   // endpoint model that fills in the expected columns
   task automatic add_row(input action_e action, input manycore_pkg::packet_s pkt);
      row_s                  row;
      manycore_pkg::packet_s head;
      row = '0;
      row.action = action;
      row.pkt = pkt;
      case (action)
         act_inject: model_q.push_back(pkt);
         act_yumi:
         begin
            head = model_q.pop_front();
            row.exp_rev_v = 1'b1;
            row.exp_ret.x_cord = head.src_x;
            row.exp_ret.y_cord = head.src_y;
         end
         act_launch:
         begin
            if (model_credits > 0)
            begin
               model_credits--;
               row.exp_fwd_v = 1'b1;
            end
         end
         act_credit: model_credits++;
         default: ;
      endcase
      // freeze commands leave the head on their own one cycle later
      if (model_q.size() > 0 && model_q[0].op != manycore_pkg::op_store)
      begin
         head = model_q.pop_front();
         model_freeze = (head.op == manycore_pkg::op_freeze);
         row.exp_rev_v = 1'b1;
         row.exp_ret.x_cord = head.src_x;
         row.exp_ret.y_cord = head.src_y;
         row.settle = 1;
      end
      row.exp_in_v = (model_q.size() > 0);
      if (row.exp_in_v)
      begin
         row.exp_store.addr = model_q[0].addr;
         row.exp_store.data = model_q[0].data;
         row.exp_store.mask = model_q[0].mask;
      end
      row.exp_credits   = manycore_pkg::credit_t'(model_credits);
      row.exp_freeze    = model_freeze;
      row.exp_out_ready = (model_credits != 0);
      row.exp_fwd_ready = (model_q.size() < manycore_pkg::fifo_els);
      table_q.push_back(row);
   endtask

   task automatic check_store(input manycore_pkg::store_req_s actual,
                              input manycore_pkg::store_req_s expected, input string what);
      if (actual !== expected)
      begin
         $display("[ERROR] %0t: %s expected addr %h data %h mask %h, got addr %h data %h mask %h",
                  $time, what, expected.addr, expected.data, expected.mask,
                  actual.addr, actual.data, actual.mask);
         row_errors++;
      end
   endtask

   task automatic check_packet(input manycore_pkg::packet_s actual,
                               input manycore_pkg::packet_s expected, input string what);
      if (actual !== expected)
      begin
         $display("[ERROR] %0t: %s expected %h, got %h", $time, what, expected, actual);
         row_errors++;
      end
   endtask

   task automatic check_return(input manycore_pkg::return_packet_s actual,
                               input manycore_pkg::return_packet_s expected, input string what);
      if (actual !== expected)
      begin
         $display("[ERROR] %0t: %s expected x %0d y %0d, got x %0d y %0d", $time, what,
                  expected.x_cord, expected.y_cord, actual.x_cord, actual.y_cord);
         row_errors++;
      end
   endtask

   task automatic check_credits(input manycore_pkg::credit_t actual,
                                input manycore_pkg::credit_t expected, input string what);
      if (actual !== expected)
      begin
         $display("[ERROR] %0t: %s expected %0d, got %0d", $time, what, expected, actual);
         row_errors++;
      end
   endtask

   task automatic check_flag(input logic actual, input logic expected, input string what);
      if (actual !== expected)
      begin
         $display("[ERROR] %0t: %s expected %b, got %b", $time, what, expected, actual);
         row_errors++;
      end
   endtask

   // stimulus lasts one cycle and results are checked on the falling edge
   task automatic apply_row(input row_s row);
      @(posedge clk_i);
      case (row.action)
         act_inject:
         begin
            link_sif_i.fwd.v    <= 1'b1;
            link_sif_i.fwd.data <= row.pkt;
         end
         act_yumi:   in_yumi_i <= 1'b1;
         act_launch:
         begin
            out_v_i      <= 1'b1;
            out_packet_i <= row.pkt;
         end
         act_credit: link_sif_i.rev.v <= 1'b1;
         default: ;
      endcase
      @(negedge clk_i);
      check_flag(link_sif_o.fwd.v, row.exp_fwd_v, "forward link valid");
      if (row.exp_fwd_v)
         check_packet(link_sif_o.fwd.data, row.pkt, "forward link data");
      @(posedge clk_i);
      link_sif_i.fwd.v <= 1'b0;
      link_sif_i.rev.v <= 1'b0;
      in_yumi_i        <= 1'b0;
      out_v_i          <= 1'b0;
      repeat (row.settle) @(posedge clk_i);
      @(negedge clk_i);
      check_flag(in_v_o, row.exp_in_v, "in_v_o");
      if (row.exp_in_v)
         check_store(in_store_o, row.exp_store, "in_store_o");
      check_flag(link_sif_o.rev.v, row.exp_rev_v, "return valid");
      if (row.exp_rev_v)
         check_return(link_sif_o.rev.data, row.exp_ret, "return packet");
      check_credits(out_credits_o, row.exp_credits, "out_credits_o");
      check_flag(freeze_r_o, row.exp_freeze, "freeze_r_o");
      check_flag(out_ready_o, row.exp_out_ready, "out_ready_o");
      check_flag(link_sif_o.fwd_ready, row.exp_fwd_ready, "forward ready");
   endtask

   initial
   begin
      manycore_pkg::packet_s idle_pkt;
      reset_i                    = 1'b1;
      link_sif_i                 = '0;
      link_sif_i.fwd_ready       = 1'b1;
      my_x_i                     = 4'd2;
      my_y_i                     = 4'd3;
      // credits always come back addressed to this tile
      link_sif_i.rev.data.x_cord = 4'd2;
      link_sif_i.rev.data.y_cord = 4'd3;
      in_yumi_i                  = 1'b0;
      out_v_i                    = 1'b0;
      out_packet_i               = '0;
      idle_pkt                   = '0;
      model_credits              = manycore_pkg::max_out_credits;
      model_freeze               = manycore_pkg::freeze_init;

      add_row(act_idle, idle_pkt);
      add_row(act_inject, make_packet(manycore_pkg::op_unfreeze, 4'd1, 4'd1));
      add_row(act_inject, make_packet(manycore_pkg::op_freeze, 4'd4, 4'd5));
      add_row(act_inject, make_packet(manycore_pkg::op_unfreeze, 4'd6, 4'd7));
      add_row(act_inject, make_packet(manycore_pkg::op_store, 4'd1, 4'd2));
      add_row(act_yumi, idle_pkt);
      // drain all credits and try one launch that must be held off
      for (int i = 0; i <= manycore_pkg::max_out_credits; i++)
         add_row(act_launch, make_packet(manycore_pkg::op_store, 4'd2, 4'd3));
      add_row(act_credit, idle_pkt);
      add_row(act_launch, make_packet(manycore_pkg::op_store, 4'd2, 4'd3));
      for (int i = 0; i < manycore_pkg::max_out_credits; i++)
         add_row(act_credit, idle_pkt);
      // fill the input FIFO and drain it again
      for (int i = 0; i < manycore_pkg::fifo_els; i++)
         add_row(act_inject, make_packet(manycore_pkg::op_store, 4'(i + 8), 4'(i + 1)));
      for (int i = 0; i < manycore_pkg::fifo_els; i++)
         add_row(act_yumi, idle_pkt);
      add_row(act_idle, idle_pkt);
      timeout_limit = table_q.size() * 20 + 100;
      table_ready = 1'b1;

      repeat (8) @(posedge clk_i);
      reset_i <= 1'b0;

      foreach (table_q[i])
      begin
         row_errors = 0;
         apply_row(table_q[i]);
         if (row_errors == 0)
            pass_count++;
         else
            fail_count++;
         $display("test %0d %s: %s", i, table_q[i].action.name(),
                  (row_errors == 0) ? "ok" : "FAILED");
      end

      $display("%0d tests passed, %0d tests failed", pass_count, fail_count);
      if (fail_count == 0)
         $display("sim passed");
      else
         $display("sim failed");
      $finish;
   end

   initial
   begin
      cycle_count = 0;
      wait (table_ready);
      while (cycle_count < timeout_limit)
      begin
         @(posedge clk_i);
         cycle_count++;
      end
      $display("timeout: tests did not finish within %0d cycles", timeout_limit);
      $display("sim failed");
      $finish;
   end

endmodule

// ==== src.f ====
source/manycore_pkg.sv
source/packet_fifo.sv
source/network_endpoint.sv
source/packet_decode.sv
source/credit_counter.sv
source/endpoint_standard.sv
tests/tb_endpoint_standard.sv

// ==== Makefile ====
TOOL     = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = tb_endpoint_standard
FILELIST = src.f
OBJ_DIR  = obj_dir
PASS_MSG = sim passed

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# fails unless the pass message shows up on a line of its own
run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
